/* dmem_pkg.sv */
package dmem_pkg;

	// One data word, also used for byte addresses.
	typedef logic [31:0] word_t;

	// Line flags.
	//   valid=1 dirty=0 : clean, matches memory.
	//   valid=1 dirty=1 : modified, memory is stale.
	//   valid=0         : empty.
	typedef struct packed {
		word_t       data;
		logic [29:0] tag;
		logic        dirty;
		logic        valid;
	} cache_line_t;

	// Pattern written to every line while the cache initializes.
	localparam cache_line_t EMPTY_LINE = '0;

	// Build a valid line holding one word for a byte address.
	function automatic cache_line_t make_line(word_t data, word_t address, logic dirty);
		cache_line_t line;
		line.data = data;
		line.tag = address[31:2];
		line.dirty = dirty;
		line.valid = 1'b1;
		return line;
	endfunction

	// The tag holds all word address bits, so a match needs no index compare.
	function automatic logic line_hit(cache_line_t line, word_t address);
		return line.valid && (line.tag == address[31:2]);
	endfunction

	// Byte address of the word held in a line.
	function automatic word_t line_address(cache_line_t line);
		return {line.tag, 2'b00};
	endfunction

endpackage

/* mem_bus_if.sv */
`timescale 1ns/1ps

// Request/ready bus between the cache and the backing memory.
// The master holds request and its operands until ready pulses,
// then drops request in the following cycle.
interface mem_bus_if import dmem_pkg::*; ();

	logic  request;
	logic  rw;       // 1 means write.
	word_t address;
	word_t wdata;
	word_t rdata;
	logic  ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

/* sync_ram.sv */
`timescale 1ns/1ps

// Single-port RAM with a registered read port.
module sync_ram import dmem_pkg::*; #(
	parameter int DEPTH_BITS = 4,
	parameter type item_t = word_t
) (
	input  logic                  i_clock,
	input  logic                  i_write,
	input  logic [DEPTH_BITS-1:0] i_address,
	input  item_t                 i_wdata,
	output item_t                 o_rdata
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	item_t mem [DEPTH];

	// Contents start cleared.
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Read returns the old word on a same-cycle write.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
		o_rdata <= mem[i_address];
	end

endmodule

/* dcache.sv */
`timescale 1ns/1ps

// Direct-mapped write-back data cache, one word per line.
module dcache import dmem_pkg::*; #(
	parameter int INDEX_BITS = 4
) (
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_request,
	input  logic  i_rw,
	input  logic  i_flush,
	input  logic  i_cacheable,
	input  word_t i_address,
	input  word_t i_wdata,
	output logic  o_ready,
	output word_t o_rdata,
	mem_bus_if.master bus
);

	typedef enum logic [3:0] {
		INITIALIZE,
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT
	} state_t;

	state_t state;

	// Shared by the init sweep and the flush sweep; top bit marks the end.
	logic [INDEX_BITS:0] sweep_index;

	logic                  ram_write;
	logic [INDEX_BITS-1:0] ram_address;
	cache_line_t           ram_wdata;
	cache_line_t           line;

	logic hit;
	logic victim_dirty;

	sync_ram #(
		.DEPTH_BITS(INDEX_BITS),
		.item_t(cache_line_t)
	) line_ram_i (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(line)
	);

	// The line at the request index is valid one cycle after IDLE.
	assign hit = line_hit(line, i_address);
	assign victim_dirty = line.valid && line.dirty;

	// ============================================================
	// Line store port
	// ============================================================
	always_comb begin
		ram_write = 1'b0;
		ram_wdata = make_line(i_wdata, i_address, 1'b1);
		ram_address = i_address[INDEX_BITS+1:2];
		case (state)
			INITIALIZE: begin
				ram_address = sweep_index[INDEX_BITS-1:0];
				ram_write = !sweep_index[INDEX_BITS];
				ram_wdata = EMPTY_LINE;
			end
			FLUSH_SETUP, FLUSH_CHECK: begin
				ram_address = sweep_index[INDEX_BITS-1:0];
			end
			FLUSH_WRITE: begin
				// Same word back, now clean.
				ram_address = sweep_index[INDEX_BITS-1:0];
				ram_write = bus.ready;
				ram_wdata = make_line(bus.wdata, bus.address, 1'b0);
			end
			WRITE_SETUP: ram_write = hit || !victim_dirty;
			WRITE_WAIT: ram_write = bus.ready;
			READ_BUS_WAIT: begin
				ram_write = bus.ready;
				ram_wdata = make_line(bus.rdata, i_address, 1'b0);
			end
			default: ;
		endcase
	end

	// ============================================================
	// Controller
	// ============================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			sweep_index <= '0;
			o_ready <= 1'b0;
			bus.request <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				INITIALIZE: begin
					if (!sweep_index[INDEX_BITS]) begin
						sweep_index <= sweep_index + 1'b1;
					end else begin
						sweep_index <= '0;
						state <= IDLE;
					end
				end

				IDLE: begin
					// o_ready still high means the requester has not dropped yet.
					if (i_request && !o_ready) begin
						if (i_flush) begin
							sweep_index <= '0;
							state <= FLUSH_SETUP;
						end else if (!i_cacheable) begin
							bus.rw <= i_rw;
							bus.address <= i_address;
							bus.wdata <= i_wdata;
							bus.request <= 1'b1;
							state <= PASS_THROUGH;
						end else if (i_rw) begin
							state <= WRITE_SETUP;
						end else begin
							state <= READ_SETUP;
						end
					end
				end

				FLUSH_SETUP: begin
					if (sweep_index[INDEX_BITS]) begin
						sweep_index <= '0;
						o_ready <= 1'b1;
						state <= IDLE;
					end else begin
						state <= FLUSH_CHECK;
					end
				end

				FLUSH_CHECK: begin
					if (victim_dirty) begin
						bus.rw <= 1'b1;
						bus.address <= line_address(line);
						bus.wdata <= line.data;
						bus.request <= 1'b1;
						state <= FLUSH_WRITE;
					end else begin
						sweep_index <= sweep_index + 1'b1;
						state <= FLUSH_SETUP;
					end
				end

				FLUSH_WRITE: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						sweep_index <= sweep_index + 1'b1;
						state <= FLUSH_SETUP;
					end
				end

				PASS_THROUGH: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						o_rdata <= bus.rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				// Write hit or clean victim is stored right away.
				WRITE_SETUP: begin
					if (hit || !victim_dirty) begin
						o_ready <= 1'b1;
						state <= IDLE;
					end else begin
						bus.rw <= 1'b1;
						bus.address <= line_address(line);
						bus.wdata <= line.data;
						bus.request <= 1'b1;
						state <= WRITE_WAIT;
					end
				end

				WRITE_WAIT: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				READ_SETUP: begin
					if (hit) begin
						o_rdata <= line.data;
						o_ready <= 1'b1;
						state <= IDLE;
					end else if (victim_dirty) begin
						bus.rw <= 1'b1;
						bus.address <= line_address(line);
						bus.wdata <= line.data;
						bus.request <= 1'b1;
						state <= READ_WB_WAIT;
					end else begin
						bus.rw <= 1'b0;
						bus.address <= i_address;
						bus.request <= 1'b1;
						state <= READ_BUS_WAIT;
					end
				end

				READ_WB_WAIT: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						state <= READ_BUS_WAIT;
					end
				end

				// After a write-back the request is raised again one cycle later.
				READ_BUS_WAIT: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						o_rdata <= bus.rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end else begin
						bus.rw <= 1'b0;
						bus.address <= i_address;
						bus.request <= 1'b1;
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* wait_state_memory.sv */
`timescale 1ns/1ps

// Word memory behind the bus, answering after MEM_WAIT wait states.
module wait_state_memory import dmem_pkg::*; #(
	parameter int MEM_ADDR_BITS = 8,
	parameter int MEM_WAIT = 2
) (
	input logic i_clock,
	input logic i_reset,
	mem_bus_if.slave bus
);

	localparam int COUNT_BITS = $clog2(MEM_WAIT + 2);

	logic                     busy;
	logic [COUNT_BITS-1:0]    wait_count;
	logic                     done;
	logic [MEM_ADDR_BITS-1:0] word_index;

	// Upper address bits are dropped, so memory aliases.
	assign word_index = bus.address[MEM_ADDR_BITS+1:2];
	assign done = busy && (wait_count == COUNT_BITS'(MEM_WAIT));

	sync_ram #(
		.DEPTH_BITS(MEM_ADDR_BITS),
		.item_t(word_t)
	) word_ram_i (
		.i_clock(i_clock),
		.i_write(done && bus.rw),
		.i_address(word_index),
		.i_wdata(bus.wdata),
		.o_rdata(bus.rdata)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			wait_count <= '0;
			bus.ready <= 1'b0;
		end else begin
			bus.ready <= 1'b0;
			if (done) begin
				busy <= 1'b0;
				bus.ready <= 1'b1;
			end else if (busy) begin
				wait_count <= wait_count + 1'b1;
			end else if (bus.request && !bus.ready) begin
				// Request still high right after ready is the old one.
				busy <= 1'b1;
				wait_count <= '0;
			end
		end
	end

endmodule

/* dmem_top.sv */
`timescale 1ns/1ps

// Data memory subsystem: cache in front of a wait-state memory.
module dmem_top import dmem_pkg::*; #(
	parameter int INDEX_BITS = 4,
	parameter int MEM_ADDR_BITS = 8,
	parameter int MEM_WAIT = 2
) (
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_request,
	input  logic  i_rw,
	input  logic  i_flush,
	input  logic  i_cacheable,
	input  word_t i_address,
	input  word_t i_wdata,
	output logic  o_ready,
	output word_t o_rdata
);

	mem_bus_if bus_i ();

	dcache #(
		.INDEX_BITS(INDEX_BITS)
	) dcache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_flush(i_flush),
		.i_cacheable(i_cacheable),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.bus(bus_i.master)
	);

	wait_state_memory #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_WAIT(MEM_WAIT)
	) memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(bus_i.slave)
	);

endmodule

/* dmem_chk.sv */
`timescale 1ns/1ps

// Handshake checks on the CPU port and the memory bus.
module dmem_chk import dmem_pkg::*; (
	input logic  i_clock,
	input logic  i_reset,
	input logic  i_request,
	input logic  i_ready,
	input logic  i_bus_request,
	input logic  i_bus_ready,
	input word_t i_bus_address
);

	int violations = 0;

	// Everything quiet while reset is applied.
	reset_quiet: assert property (@(posedge i_clock)
		i_reset |=> (!i_ready && !i_bus_request && !i_bus_ready))
		else begin
			violations++;
			$error("ready or bus request high during reset");
		end

	// o_ready is a single-cycle pulse.
	ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |=> !i_ready)
		else begin
			violations++;
			$error("o_ready high in two consecutive cycles");
		end

	ready_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |-> i_request)
		else begin
			violations++;
			$error("o_ready raised without a pending request");
		end

	// The master holds its request and address until the slave answers.
	bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=> (i_bus_request && $stable(i_bus_address)))
		else begin
			violations++;
			$error("bus request dropped or address changed before ready");
		end

endmodule

bind dmem_top dmem_chk dmem_chk_i (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_bus_request(bus_i.request),
	.i_bus_ready(bus_i.ready),
	.i_bus_address(bus_i.address)
);

/* tb_dmem.sv */
`timescale 1ns/1ps

module tb_dmem import dmem_pkg::*; ();

	localparam int INDEX_BITS = 4;
	localparam int MEM_ADDR_BITS = 8;
	localparam int MEM_WAIT = 2;
	localparam int CLOCK_PERIOD = 4;
	localparam int RANDOM_OPS = 200;
	localparam int TOTAL_OPS = RANDOM_OPS + 24;
	localparam int LINES = 1 << INDEX_BITS;
	localparam int TIMEOUT_CYCLES =
		2 * (TOTAL_OPS * 2 * (MEM_WAIT + 4) + LINES * (MEM_WAIT + 6) + LINES + 8);

	logic  clock = 1'b0;
	logic  reset;
	logic  request;
	logic  rw;
	logic  flush;
	logic  cacheable;
	word_t address;
	word_t wdata;
	logic  ready;
	word_t rdata;

	// Memory as the CPU sees it with one entry per word index.
	word_t shadow [int];
	word_t expected_rdata = '0;
	int    error_count = 0;
	int    access_count = 0;

	dmem_top #(
		.INDEX_BITS(INDEX_BITS),
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_WAIT(MEM_WAIT)
	) dmem_top_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_rw(rw),
		.i_flush(flush),
		.i_cacheable(cacheable),
		.i_address(address),
		.i_wdata(wdata),
		.o_ready(ready),
		.o_rdata(rdata)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// ============================================================
	// Read data checks
	// ============================================================
	read_data_check: assert property (@(posedge clock) disable iff (reset)
		(ready && !rw && !flush) |-> (rdata == expected_rdata))
		else begin
			error_count++;
			$display("ERROR: time %0t o_rdata got %h expected %h",
				$time, $sampled(rdata), $sampled(expected_rdata));
		end

	// Bits above the memory size alias onto the same word.
	function automatic int word_key(input word_t addr);
		return int'(addr[MEM_ADDR_BITS+1:2]);
	endfunction

	function automatic word_t model_read(input word_t addr);
		if (shadow.exists(word_key(addr))) begin
			return shadow[word_key(addr)];
		end
		return '0;
	endfunction

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int total_errors();
		return error_count + dmem_top_i.dmem_chk_i.violations;
	endfunction

	// One CPU request that is held until o_ready and through the edge that samples it.
	task automatic access(input logic is_write, input logic is_cacheable,
		input logic is_flush, input word_t addr, input word_t data);
		@(posedge clock);
		#1;
		rw = is_write;
		cacheable = is_cacheable;
		flush = is_flush;
		address = addr;
		wdata = data;
		expected_rdata = model_read(addr);
		request = 1'b1;
		do begin
			@(posedge clock);
			#1;
		end while (!ready);
		@(posedge clock);
		#1;
		request = 1'b0;
		if (is_write && !is_flush) begin
			shadow[word_key(addr)] = data;
		end
		access_count++;
	endtask

	task automatic report_test(input string name, input int errors_before,
		input int accesses_before);
		$display("test %s: %0d accesses, %0d errors", name,
			access_count - accesses_before, total_errors() - errors_before);
	endtask

	// Watchdog.
	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [31:0] rng;
		word_t       addr;
		int          errors_before;
		int          accesses_before;

		rng = 32'h3175;
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		flush = 1'b0;
		cacheable = 1'b0;
		address = '0;
		wdata = '0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;

		// Hit path.
		errors_before = total_errors();
		accesses_before = access_count;
		access(1'b1, 1'b1, 1'b0, 32'h0000_0020, 32'hcafe_0001);
		access(1'b0, 1'b1, 1'b0, 32'h0000_0020, '0);
		report_test("hit", errors_before, accesses_before);

		// Both addresses share an index so the second write evicts a dirty line.
		errors_before = total_errors();
		accesses_before = access_count;
		access(1'b1, 1'b1, 1'b0, 32'h0000_0010, 32'h1111_aaaa);
		access(1'b1, 1'b1, 1'b0, 32'h0000_0050, 32'h2222_bbbb);
		access(1'b0, 1'b1, 1'b0, 32'h0000_0010, '0);
		access(1'b0, 1'b1, 1'b0, 32'h0000_0050, '0);
		report_test("write_back", errors_before, accesses_before);

		// Pass-through in the upper half.
		errors_before = total_errors();
		accesses_before = access_count;
		for (int k = 0; k < 4; k++) begin
			access(1'b1, 1'b0, 1'b0, 32'h0000_0200 + 32'(k * 4), 32'h3000_0000 + 32'(k));
		end
		access(1'b1, 1'b0, 1'b0, 32'h0000_0204, 32'h3333_cccc);
		for (int k = 0; k < 4; k++) begin
			access(1'b0, 1'b0, 1'b0, 32'h0000_0200 + 32'(k * 4), '0);
		end
		report_test("pass_through", errors_before, accesses_before);

		// Flush and then read the words back through the aliased addresses.
		errors_before = total_errors();
		accesses_before = access_count;
		for (int k = 0; k < 4; k++) begin
			access(1'b1, 1'b1, 1'b0, 32'h0000_0100 + 32'(k * 4), 32'h4000_0000 + 32'(k));
		end
		access(1'b0, 1'b1, 1'b1, '0, '0);
		for (int k = 0; k < 4; k++) begin
			access(1'b0, 1'b0, 1'b0, 32'h0000_0500 + 32'(k * 4), '0);
		end
		report_test("flush", errors_before, accesses_before);

		// Random cacheable traffic over the lower half.
		errors_before = total_errors();
		accesses_before = access_count;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			rng = next_random(rng);
			addr = rng & 32'h0000_01fc;
			rng = next_random(rng);
			access(rng[0], 1'b1, 1'b0, addr, rng);
		end
		report_test("random", errors_before, accesses_before);

		repeat (2) @(posedge clock);
		$display("Summary: %0d accesses, %0d data errors, %0d handshake violations",
			access_count, error_count, dmem_top_i.dmem_chk_i.violations);
		if (total_errors() == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* all.f */
dmem_pkg.sv
mem_bus_if.sv
sync_ram.sv
dcache.sv
wait_state_memory.sv
dmem_top.sv
dmem_chk.sv
tb_dmem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_dmem -f all.f -o sim_dmem
output=$(./obj_dir/sim_dmem +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
